// ==== rtl/limb_adder.sv ====
`timescale 1ns/10ps
`default_nettype none

module limb_adder (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire mont_types_pkg::add_req_t   req,
    output mont_types_pkg::add_rsp_t        rsp
);

    mont_types_pkg::acc_t a_q;   // remaining limbs of a, low limb next
    mont_types_pkg::acc_t b_q;   // remaining limbs of b, already inverted on subtract
    mont_types_pkg::acc_t sum_q; // finished limbs enter from the top
    mont_types_pkg::acc_t opa;
    mont_types_pkg::acc_t opb;
    logic                 cin;
    logic                 carry_q;
    logic                 busy;
    logic                 done_q;
    logic                 step;  // one limb this cycle
    logic [mont_cfg_pkg::LIMB_CNT_W-1:0] limbs_left;
    logic [mont_cfg_pkg::LIMB_W:0]       limb_sum;   // limb plus carry out

    // start cycle adds limb 0 straight from the request
    always_comb begin
        opa      = req.start ? req.a : a_q;
        opb      = req.start ? (req.subtract ? ~req.b : req.b) : b_q;
        cin      = req.start ? req.subtract : carry_q; // +1 completes two's complement
        step     = req.start || busy;
        limb_sum = {1'b0, opa[mont_cfg_pkg::LIMB_W-1:0]}
                 + {1'b0, opb[mont_cfg_pkg::LIMB_W-1:0]}
                 + {{mont_cfg_pkg::LIMB_W{1'b0}}, cin};
    end

    always_ff @(posedge clk) begin
        if (step) begin
            a_q   <= opa >> mont_cfg_pkg::LIMB_W;
            b_q   <= opb >> mont_cfg_pkg::LIMB_W;
            sum_q <= {limb_sum[mont_cfg_pkg::LIMB_W-1:0], sum_q[mont_cfg_pkg::ACC_W-1:mont_cfg_pkg::LIMB_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy       <= 1'b0;
            done_q     <= 1'b0;
            carry_q    <= 1'b0;
            limbs_left <= '0;
        end else begin
            done_q <= 1'b0;
            if (step) begin
                carry_q <= limb_sum[mont_cfg_pkg::LIMB_W]; // ripple to next limb
            end
            if (req.start) begin
                busy       <= 1'b1;
                limbs_left <= mont_cfg_pkg::LIMB_CNT_INIT;
            end else if (busy) begin
                if (limbs_left == '0) begin // top limb just written
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    limbs_left <= limbs_left - 1'b1;
                end
            end
        end
    end

    always_comb begin
        rsp.done = done_q;
        rsp.sum  = sum_q; // stable until the next start
    end

endmodule

`default_nettype wire

// ==== rtl/mont_cfg_pkg.sv ====
`default_nettype none

package mont_cfg_pkg;

    // operand width, reduced from the 1024 bit reference
    localparam int OPERAND_W = 64;

    // accumulator keeps c + 3b + 3m plus a sign bit
    localparam int ACC_W = OPERAND_W + 4;

    // adder slice per cycle
    localparam int LIMB_W    = 17;
    localparam int NUM_LIMBS = ACC_W / LIMB_W; // 4 limbs

    // two bits of a per iteration
    localparam int NUM_DIGITS = OPERAND_W / 2;

    // counter widths
    localparam int LIMB_CNT_W  = $clog2(NUM_LIMBS);
    localparam int DIGIT_CNT_W = $clog2(NUM_DIGITS);

    // limb 0 is added in the start cycle, the counter covers the rest
    localparam logic [LIMB_CNT_W-1:0]  LIMB_CNT_INIT  = LIMB_CNT_W'(NUM_LIMBS - 2);
    localparam logic [DIGIT_CNT_W-1:0] DIGIT_CNT_INIT = DIGIT_CNT_W'(NUM_DIGITS - 1);

endpackage

`default_nettype wire

// ==== rtl/mont_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module mont_ctrl (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         start,
    input  wire                         add_done,
    output logic                        load,
    output logic                        prep,
    output mont_types_pkg::dp_op_e      op,
    output logic                        done
);

    mont_types_pkg::ctrl_state_e state;
    mont_types_pkg::ctrl_state_e state_n;
    mont_types_pkg::dp_op_e      op_n;
    logic                        entering;  // state changes this cycle
    logic [mont_cfg_pkg::DIGIT_CNT_W-1:0] digit_cnt; // iterations left after this one

    always_comb begin
        state_n = state;
        case (state)
            mont_types_pkg::ST_IDLE: begin
                if (start) begin // start only seen here
                    state_n = mont_types_pkg::ST_LOAD;
                end
            end
            mont_types_pkg::ST_LOAD: state_n = mont_types_pkg::ST_PREP;
            mont_types_pkg::ST_PREP: state_n = mont_types_pkg::ST_ADD_B;
            mont_types_pkg::ST_ADD_B: begin
                if (add_done) begin
                    state_n = mont_types_pkg::ST_ADD_M;
                end
            end
            mont_types_pkg::ST_ADD_M: begin
                if (add_done) begin
                    state_n = mont_types_pkg::ST_SHIFT;
                end
            end
            mont_types_pkg::ST_SHIFT: begin
                state_n = (digit_cnt == '0) ? mont_types_pkg::ST_SUB : mont_types_pkg::ST_ADD_B;
            end
            mont_types_pkg::ST_SUB: begin
                if (add_done) begin
                    state_n = mont_types_pkg::ST_DONE;
                end
            end
            mont_types_pkg::ST_DONE: state_n = mont_types_pkg::ST_IDLE;
            default:                 state_n = mont_types_pkg::ST_IDLE;
        endcase
    end

    assign entering = (state_n != state);

    // op lands in the first cycle of the new state
    always_comb begin
        op_n = mont_types_pkg::OP_NONE;
        if (entering) begin
            case (state_n)
                mont_types_pkg::ST_LOAD:  op_n = mont_types_pkg::OP_CLEAR;
                mont_types_pkg::ST_ADD_B: op_n = mont_types_pkg::OP_ADD_B;
                mont_types_pkg::ST_ADD_M: op_n = mont_types_pkg::OP_ADD_M;
                mont_types_pkg::ST_SHIFT: op_n = mont_types_pkg::OP_SHIFT;
                mont_types_pkg::ST_SUB:   op_n = mont_types_pkg::OP_SUB;
                default:                  op_n = mont_types_pkg::OP_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= mont_types_pkg::ST_IDLE;
            op        <= mont_types_pkg::OP_NONE;
            load      <= 1'b0;
            prep      <= 1'b0;
            done      <= 1'b0;
            digit_cnt <= '0;
        end else begin
            state <= state_n;
            op    <= op_n;
            load  <= (state_n == mont_types_pkg::ST_LOAD); // one cycle states
            prep  <= (state_n == mont_types_pkg::ST_PREP);
            done  <= (state_n == mont_types_pkg::ST_DONE);
            if (state == mont_types_pkg::ST_LOAD) begin
                digit_cnt <= mont_cfg_pkg::DIGIT_CNT_INIT;
            end else if (state == mont_types_pkg::ST_SHIFT) begin
                digit_cnt <= digit_cnt - 1'b1; // one iteration finished
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mont_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module mont_datapath (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire mont_types_pkg::operand_t   a,
    input  wire mont_types_pkg::dp_op_e     op,
    input  wire mont_types_pkg::multiples_t multiples,
    output mont_types_pkg::add_req_t        add_req,
    input  wire mont_types_pkg::add_rsp_t   add_rsp,
    output mont_types_pkg::operand_t        result
);

    mont_types_pkg::acc_t     c_q;      // accumulator
    mont_types_pkg::operand_t a_sh;     // a digits, current one in [1:0]
    mont_types_pkg::acc_t     addend;   // selected multiple
    logic                     pend_sub; // outstanding add is the final subtract
    logic [1:0]               q_digit;  // quotient digit

    // 0, x, 2x or 3x by digit
    function automatic mont_types_pkg::acc_t pick_multiple(
        input logic [1:0]           digit,
        input mont_types_pkg::acc_t x1,
        input mont_types_pkg::acc_t x2,
        input mont_types_pkg::acc_t x3
    );
        mont_types_pkg::acc_t sel;
        case (digit)
            2'd1:    sel = x1;
            2'd2:    sel = x2;
            2'd3:    sel = x3;
            default: sel = '0;
        endcase
        return sel;
    endfunction

    // q makes c + q*m divisible by 4, m is odd
    always_comb begin
        q_digit = 2'd0;
        case (c_q[1:0])
            2'b00: q_digit = 2'd0;
            2'b10: q_digit = 2'd2;
            2'b01: q_digit = multiples.m1[1] ? 2'd1 : 2'd3; // m 11 -> 1, m 01 -> 3
            2'b11: q_digit = multiples.m1[1] ? 2'd3 : 2'd1; // m 11 -> 3, m 01 -> 1
        endcase
    end

    always_comb begin
        case (op)
            mont_types_pkg::OP_ADD_B: addend = pick_multiple(a_sh[1:0], multiples.b1,
                                                             multiples.b2, multiples.b3);
            mont_types_pkg::OP_ADD_M: addend = pick_multiple(q_digit, multiples.m1,
                                                             multiples.m2, multiples.m3);
            mont_types_pkg::OP_SUB:   addend = multiples.m1;
            default:                  addend = '0;
        endcase
    end

    // request goes out in the op cycle
    always_comb begin
        add_req.start    = (op == mont_types_pkg::OP_ADD_B) || (op == mont_types_pkg::OP_ADD_M)
                        || (op == mont_types_pkg::OP_SUB);
        add_req.subtract = (op == mont_types_pkg::OP_SUB);
        add_req.a        = c_q;
        add_req.b        = addend;
    end

    // accumulator and digit shifter
    always_ff @(posedge clk) begin
        case (op)
            mont_types_pkg::OP_CLEAR: begin
                c_q  <= '0;
                a_sh <= a;
            end
            mont_types_pkg::OP_SHIFT: begin
                c_q  <= c_q >> 2;  // exact divide by 4
                a_sh <= a_sh >> 2; // next digit down
            end
            default: begin
                if (add_rsp.done && !pend_sub) begin
                    c_q <= add_rsp.sum;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend_sub <= 1'b0;
            result   <= '0;
        end else begin
            if (op == mont_types_pkg::OP_SUB) begin
                pend_sub <= 1'b1;
            end else if (op == mont_types_pkg::OP_CLEAR) begin
                pend_sub <= 1'b0;
            end
            if (add_rsp.done && pend_sub) begin
                pend_sub <= 1'b0;
                // negative difference means c already below m
                result <= add_rsp.sum[mont_cfg_pkg::ACC_W-1]
                        ? c_q[mont_cfg_pkg::OPERAND_W-1:0]
                        : add_rsp.sum[mont_cfg_pkg::OPERAND_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mont_types_pkg.sv ====
`default_nettype none

package mont_types_pkg;

    typedef logic [mont_cfg_pkg::OPERAND_W-1:0] operand_t; // a, b, m, result
    typedef logic [mont_cfg_pkg::ACC_W-1:0]     acc_t;     // accumulator width values

    // precomputed multiples, all zero extended to acc width
    typedef struct packed {
        acc_t b1;
        acc_t b2;
        acc_t b3;
        acc_t m1;
        acc_t m2;
        acc_t m3;
    } multiples_t;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_LOAD  = 3'd1, // capture operands
        ST_PREP  = 3'd2, // build 3b and 3m
        ST_ADD_B = 3'd3, // c += digit * b
        ST_ADD_M = 3'd4, // c += q * m
        ST_SHIFT = 3'd5, // c >>= 2
        ST_SUB   = 3'd6, // final c - m
        ST_DONE  = 3'd7
    } ctrl_state_e;

    // one cycle commands to the datapath
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_CLEAR = 3'd1,
        OP_ADD_B = 3'd2,
        OP_ADD_M = 3'd3,
        OP_SHIFT = 3'd4,
        OP_SUB   = 3'd5
    } dp_op_e;

    typedef struct packed {
        logic start;    // one cycle strobe
        logic subtract; // a - b when set
        acc_t a;
        acc_t b;
    } add_req_t;

    typedef struct packed {
        logic done; // one cycle, sum valid here
        acc_t sum;
    } add_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/montgomery_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module montgomery_top (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             start,
    input  wire mont_types_pkg::operand_t   a,
    input  wire mont_types_pkg::operand_t   b,
    input  wire mont_types_pkg::operand_t   m,
    output mont_types_pkg::operand_t        result,
    output logic                            done
);

    logic                       load;      // ctrl -> bank
    logic                       prep;
    mont_types_pkg::dp_op_e     op;        // ctrl -> datapath
    mont_types_pkg::multiples_t multiples; // bank -> datapath
    mont_types_pkg::add_req_t   add_req;
    mont_types_pkg::add_rsp_t   add_rsp;   // also steps the ctrl

    operand_bank bank_i (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .prep      (prep),
        .b         (b),
        .m         (m),
        .multiples (multiples)
    );

    mont_ctrl ctrl_i (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .add_done (add_rsp.done),
        .load     (load),
        .prep     (prep),
        .op       (op),
        .done     (done)
    );

    mont_datapath dp_i (
        .clk       (clk),
        .resetn    (resetn),
        .a         (a),
        .op        (op),
        .multiples (multiples),
        .add_req   (add_req),
        .add_rsp   (add_rsp),
        .result    (result)
    );

    limb_adder adder_i (
        .clk    (clk),
        .resetn (resetn),
        .req    (add_req),
        .rsp    (add_rsp)
    );

endmodule

`default_nettype wire

// ==== rtl/operand_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_bank (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             load,      // capture b and m
    input  wire                             prep,      // build the triples
    input  wire mont_types_pkg::operand_t   b,
    input  wire mont_types_pkg::operand_t   m,
    output mont_types_pkg::multiples_t      multiples
);

    mont_types_pkg::acc_t b_ext;  // zero extended b
    mont_types_pkg::acc_t m_ext;  // zero extended m
    mont_types_pkg::acc_t b3_sum;
    mont_types_pkg::acc_t m3_sum;

    always_comb begin
        b_ext = mont_types_pkg::acc_t'(b);
        m_ext = mont_types_pkg::acc_t'(m);
    end

    // 3x = x + 2x, one add per operand, settled within the prep cycle
    always_comb begin
        b3_sum = multiples.b1 + multiples.b2;
        m3_sum = multiples.m1 + multiples.m2;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            multiples <= '0;
        end else if (load) begin
            multiples.b1 <= b_ext;
            multiples.b2 <= b_ext << 1; // 2b
            multiples.m1 <= m_ext;
            multiples.m2 <= m_ext << 1; // 2m
        end else if (prep) begin
            // singles and doubles already settled from load
            multiples.b3 <= b3_sum;
            multiples.m3 <= m3_sum;
        end
        // held otherwise, for the whole multiplication
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and decide the outcome from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_montgomery -f sources.f -o tb_montgomery \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_montgomery > sim.log 2>&1
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+verification
rtl/mont_cfg_pkg.sv
rtl/mont_types_pkg.sv
rtl/operand_bank.sv
rtl/limb_adder.sv
rtl/mont_datapath.sv
rtl/mont_ctrl.sv
rtl/montgomery_top.sv
verification/tb_montgomery.sv

// ==== verification/mont_tb_util.svh ====
`ifndef MONT_TB_UTIL_SVH
`define MONT_TB_UTIL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1, output bit is s[0]
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// quotient digit from the low bits of c and m, m is odd
function automatic logic [1:0] quotient_digit(input logic [1:0] c_lo, input logic [1:0] m_lo);
    logic [1:0] q;
    case ({c_lo, m_lo})
        4'b0101, 4'b1111: q = 2'd3;
        4'b1101, 4'b0111: q = 2'd1;
        default:          q = (c_lo == 2'b10) ? 2'd2 : 2'd0; // even c
    endcase
    return q;
endfunction

// a * b * 2^-w mod m, two bits of a per pass
function automatic mont_types_pkg::operand_t mont_model(
    input mont_types_pkg::operand_t a,
    input mont_types_pkg::operand_t b,
    input mont_types_pkg::operand_t m
);
    mont_types_pkg::acc_t     c;
    mont_types_pkg::operand_t digits;
    c      = '0;
    digits = a;
    for (int i = 0; i < mont_cfg_pkg::NUM_DIGITS; i++) begin
        c      = c + mont_types_pkg::acc_t'(digits[1:0]) * mont_types_pkg::acc_t'(b);
        c      = c + mont_types_pkg::acc_t'(quotient_digit(c[1:0], m[1:0]))
                   * mont_types_pkg::acc_t'(m);
        c      = c >> 2;       // low two bits are zero here
        digits = digits >> 2;
    end
    // c stays below 2m, so one subtraction is enough
    if (c >= mont_types_pkg::acc_t'(m)) begin
        c = c - mont_types_pkg::acc_t'(m);
    end
    return mont_types_pkg::operand_t'(c);
endfunction

`endif

// ==== verification/tb_montgomery.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_montgomery;

    localparam int TIMEOUT_CYCLES = 2000; // well above one multiplication
    localparam int WATCH_CYCLES   = 500;  // longer than one multiplication

    logic                     clk;
    logic                     resetn;
    logic                     start;
    mont_types_pkg::operand_t a;
    mont_types_pkg::operand_t b;
    mont_types_pkg::operand_t m;
    mont_types_pkg::operand_t result;
    logic                     done;

    logic [31:0] lfsr_q;      // random source
    int          errors;
    int          checks;
    logic        timed_out;   // set by a wait loop that gave up
    string       hang_reason;

    `include "mont_tb_util.svh"

    montgomery_top dut_i (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // ends the run once a wait loop times out
    initial begin
        wait (timed_out);
        $display("timeout: %s", hang_reason);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // inputs change 2 ns after the edge, outputs are read there as well
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic draw_operand(output mont_types_pkg::operand_t val);
        val = '0;
        for (int i = 0; i < mont_cfg_pkg::OPERAND_W; i++) begin
            val    = {val[mont_cfg_pkg::OPERAND_W-2:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q); // one step per bit
        end
    endtask

    task automatic random_operands(output mont_types_pkg::operand_t av,
                                   output mont_types_pkg::operand_t bv,
                                   output mont_types_pkg::operand_t mv);
        draw_operand(mv);
        mv[mont_cfg_pkg::OPERAND_W-1] = 1'b1; // full width modulus
        mv[0] = 1'b1;                         // odd
        draw_operand(av);
        av = av % mv;
        draw_operand(bv);
        bv = bv % mv;
    endtask

    task automatic check_result(input mont_types_pkg::operand_t got,
                                input mont_types_pkg::operand_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, result %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_done_pulse(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, done %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (done !== 1'b1 && n < TIMEOUT_CYCLES) begin
            step();
            n++;
        end
        if (done !== 1'b1) begin
            hang_reason = $sformatf("done did not arrive within %0d cycles in %s",
                                    TIMEOUT_CYCLES, what);
            timed_out   = 1'b1;
            wait (!timed_out); // parked here, the watchdog ends the run
        end
    endtask

    task automatic launch(input mont_types_pkg::operand_t av, input mont_types_pkg::operand_t bv,
                          input mont_types_pkg::operand_t mv);
        a     = av;
        b     = bv;
        m     = mv;
        start = 1'b1; // single cycle strobe
        step();
        start = 1'b0;
    endtask

    task automatic run_mult(input mont_types_pkg::operand_t av, input mont_types_pkg::operand_t bv,
                            input mont_types_pkg::operand_t mv, input string what);
        mont_types_pkg::operand_t exp;
        exp = mont_model(av, bv, mv);
        launch(av, bv, mv);
        wait_done(what);
        check_result(result, exp, what);
        step();
        check_done_pulse(done, 1'b0, {what, ", cycle after done"});
        check_result(result, exp, {what, ", result held"});
    endtask

    task automatic busy_start_check();
        mont_types_pkg::operand_t av;
        mont_types_pkg::operand_t bv;
        mont_types_pkg::operand_t mv;
        mont_types_pkg::operand_t exp;
        random_operands(av, bv, mv);
        exp = mont_model(av, bv, mv);
        launch(av, bv, mv);
        repeat (40) step();
        random_operands(av, bv, mv); // new operands with a second start mid run
        launch(av, bv, mv);
        wait_done("busy start");
        check_result(result, exp, "start while busy");
        for (int i = 0; i < WATCH_CYCLES; i++) begin
            step();
            check_done_pulse(done, 1'b0, "extra done after busy start");
            check_result(result, exp, "result hold after done");
        end
    endtask

    task automatic reset_mid_run();
        mont_types_pkg::operand_t av;
        mont_types_pkg::operand_t bv;
        mont_types_pkg::operand_t mv;
        random_operands(av, bv, mv);
        launch(av, bv, mv);
        repeat (60) step();
        resetn = 1'b0;
        repeat (10) begin
            step();
            check_done_pulse(done, 1'b0, "done during reset");
        end
        resetn = 1'b1;
        repeat (WATCH_CYCLES) begin
            step();
            check_done_pulse(done, 1'b0, "done after aborted run");
        end
        check_result(result, '0, "result after reset");
        random_operands(av, bv, mv);
        run_mult(av, bv, mv, "first run after reset");
    endtask

    initial begin
        mont_types_pkg::operand_t av;
        mont_types_pkg::operand_t bv;
        mont_types_pkg::operand_t mv;
        resetn      = 1'b0;
        start       = 1'b0;
        a           = '0;
        b           = '0;
        m           = '0;
        lfsr_q      = 32'hb50e;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        hang_reason = "";
        repeat (10) @(posedge clk); // reset for 10 cycles
        #2;
        resetn = 1'b1;
        step();

        random_operands(av, bv, mv);
        run_mult('0, bv, mv, "edge a = 0");
        run_mult(av, '0, mv, "edge b = 0");
        run_mult(mv - 1, mv - 1, mv, "edge a = b = m-1");
        run_mult(64'd2, 64'd1, 64'd3, "edge m = 3");
        for (int i = 0; i < 60; i++) begin
            random_operands(av, bv, mv);
            run_mult(av, bv, mv, $sformatf("random %0d", i));
        end
        busy_start_check();
        reset_mid_run();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
